//--- hdl/sdram_pkg.sv
package sdram_pkg;

	// --------------------------------------------------------------------------
	// chip commands and timing
	// --------------------------------------------------------------------------

	// {ncs, nras, ncas, nwe}
	typedef enum logic [3:0] {
		CMD_LOAD_MODE    = 4'b0000,
		CMD_AUTO_REFRESH = 4'b0001,
		CMD_PRECHARGE    = 4'b0010,
		CMD_ACTIVE       = 4'b0011,
		CMD_WRITE        = 4'b0100,
		CMD_READ         = 4'b0101,
		CMD_BURST_TERM   = 4'b0110,
		CMD_NOP          = 4'b0111,
		CMD_INHIBIT      = 4'b1111
	} sdram_cmd_t;

	localparam logic [2:0] RASCAS_DELAY      = 3'd2;    // trcd, 20ns below 100MHz
	localparam logic [2:0] CAS_LATENCY       = 3'd2;
	localparam logic [2:0] BURST_LENGTH_CODE = 3'b001;  // burst of 2

	// single write, standard op, CL2, sequential, burst 2
	localparam logic [12:0] MODE_WORD = {3'b000, 1'b1, 2'b00, CAS_LATENCY, 1'b0,
		BURST_LENGTH_CODE};

	localparam logic [9:0] RFRSH_CYCLES = 10'd842;      // 64ms / 8192 rows
	localparam logic [4:0] RESET_FRAMES = 5'd31;

	// seven cycle frame, slot 0 on banks 0/1 and slot 1 on banks 2/3
	typedef enum logic [2:0] {
		PH_RAS0 = 3'd0,
		PH_1    = 3'd1,
		PH_2    = 3'd2,
		PH_CAS0 = RASCAS_DELAY + 3'd1,  // one spare cycle after trcd
		PH_RAS1 = 3'd4,
		PH_5    = 3'd5,
		PH_CAS1 = 3'd4 + RASCAS_DELAY
	} frame_phase_t;

	// capture points share cycles with the command phases
	localparam frame_phase_t PH_READ0  = PH_RAS0;  // slot 0 word, next frame
	localparam frame_phase_t PH_READ1  = PH_CAS0;  // slot 1 low word
	localparam frame_phase_t PH_READ1B = PH_RAS1;  // slot 1 high word
	localparam frame_phase_t PH_LAST   = PH_CAS1;

	typedef enum logic [1:0] {
		PORT_NONE = 2'd0,
		PORT_CPU1 = 2'd1,
		PORT_CPU2 = 2'd2,
		PORT_REQ  = 2'd3
	} port_sel_t;

	localparam port_sel_t PORT_SP = PORT_CPU1;  // first read port of slot 1

	typedef logic [15:0] word_t;
	typedef logic [31:0] dword_t;
	typedef logic [23:0] waddr_t;  // bank[23:22] row[21:9] col[8:0]

endpackage

//--- hdl/sdram_init_seq.sv
`timescale 1ns/1ps

module sdram_init_seq (
	input  logic                    clk,
	input  logic                    init_n,
	input  sdram_pkg::frame_phase_t frame_phase,
	output logic                    init_busy,
	output sdram_pkg::sdram_cmd_t   init_cmd,
	output logic                    init_a10
);

	logic [4:0] frame_cnt;  // frames left before normal operation

	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			frame_cnt <= sdram_pkg::RESET_FRAMES;
		end else if (frame_phase == sdram_pkg::PH_LAST && frame_cnt != 5'd0) begin
			frame_cnt <= frame_cnt - 5'd1;
		end
	end

	assign init_busy = (frame_cnt != 5'd0);

	// --------------------------------------------------------------------------
	// power-up sequence in the last 16 frames, one command per frame at ras0
	// --------------------------------------------------------------------------

	always_comb begin
		init_cmd = sdram_pkg::CMD_NOP;
		if (frame_phase == sdram_pkg::PH_RAS0) begin
			case (frame_cnt)
				5'd15:        init_cmd = sdram_pkg::CMD_PRECHARGE;
				5'd10, 5'd8:  init_cmd = sdram_pkg::CMD_AUTO_REFRESH;
				5'd2:         init_cmd = sdram_pkg::CMD_LOAD_MODE;
				default:      init_cmd = sdram_pkg::CMD_NOP;
			endcase
		end
	end

	// a10 high turns the precharge into precharge all
	assign init_a10 = (init_cmd == sdram_pkg::CMD_PRECHARGE);

endmodule

//--- hdl/sdram_port_arbiter.sv
`timescale 1ns/1ps

module sdram_port_arbiter #(
	parameter int SLOT = 0  // 0: banks 0/1, word reads   1: banks 2/3, dword reads
) (
	input  logic                 clk,
	input  logic                 init_n,
	input  logic                 take,       // slot ras cycle, choice is latched
	input  logic                 slot_hold,  // refresh in progress
	input  logic                 req,
	input  logic                 we,
	input  logic [1:0]           ds,
	input  sdram_pkg::word_t     d,
	input  sdram_pkg::waddr_t    a,
	input  logic [15:0]          rd0_addr,
	input  logic [15:0]          rd1_addr,
	output sdram_pkg::port_sel_t sel,
	output sdram_pkg::waddr_t    sel_addr,
	output logic                 sel_we,
	output logic [1:0]           sel_ds,
	output sdram_pkg::word_t     sel_d,
	output logic                 req_state  // toggle state last accepted
);

	localparam logic BANK_HI = (SLOT != 0);

	logic [15:0] last0;  // last serviced rd0 address
	logic [15:0] last1;

	// read port address into the slot's banks
	function automatic sdram_pkg::waddr_t map_rd(input logic [15:0] ra);
		if (SLOT == 0)
			map_rd = {BANK_HI, 7'd0, ra};        // word address
		else
			map_rd = {BANK_HI, 6'd0, ra, 1'b0};  // dword address, even word
	endfunction

	// --------------------------------------------------------------------------
	// priority choice
	// --------------------------------------------------------------------------

	always_comb begin
		sel      = sdram_pkg::PORT_NONE;
		sel_addr = {BANK_HI, a[22:0]};  // bank msb forced by slot
		sel_we   = 1'b0;
		sel_ds   = 2'b11;               // reads take both bytes
		sel_d    = d;
		if (!slot_hold) begin
			if (req != req_state) begin
				sel    = sdram_pkg::PORT_REQ;
				sel_we = we;
				sel_ds = ds;
			end else if (rd0_addr != last0) begin
				sel      = sdram_pkg::PORT_CPU1;
				sel_addr = map_rd(rd0_addr);
			end else if (rd1_addr != last1) begin
				sel      = sdram_pkg::PORT_CPU2;
				sel_addr = map_rd(rd1_addr);
			end
		end
	end

	// book-keeping once the controller has taken the choice
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			req_state <= 1'b0;
			last0     <= 16'd0;
			last1     <= 16'd0;
		end else if (take) begin
			case (sel)
				sdram_pkg::PORT_REQ:  req_state <= req;
				sdram_pkg::PORT_CPU1: last0     <= rd0_addr;
				sdram_pkg::PORT_CPU2: last1     <= rd1_addr;
				default: ;
			endcase
		end
	end

endmodule

//--- hdl/sdram_ctrl.sv
`timescale 1ns/1ps

module sdram_ctrl (
	input  logic                    clk,
	input  logic                    init_n,
	input  logic                    init_busy,
	input  sdram_pkg::sdram_cmd_t   init_cmd,
	input  logic                    init_a10,
	input  sdram_pkg::port_sel_t    sel0,
	input  sdram_pkg::waddr_t       sel0_addr,
	input  logic                    sel0_we,
	input  logic [1:0]              sel0_ds,
	input  sdram_pkg::word_t        sel0_d,
	input  sdram_pkg::port_sel_t    sel1,
	input  sdram_pkg::waddr_t       sel1_addr,
	input  logic                    sel1_we,
	input  logic [1:0]              sel1_ds,
	input  sdram_pkg::word_t        sel1_d,
	input  logic                    port1_req,  // accepted toggle from slot 0 arbiter
	input  logic                    port2_req,
	output sdram_pkg::frame_phase_t frame_phase,
	output logic                    take0,
	output logic                    take1,
	output logic                    refresh_busy,
	inout  wire  [15:0]             sdram_dq,
	output logic [12:0]             sdram_a,
	output logic [1:0]              sdram_ba,
	output logic                    sdram_dqml,
	output logic                    sdram_dqmh,
	output logic                    sdram_ncs,
	output logic                    sdram_nras,
	output logic                    sdram_ncas,
	output logic                    sdram_nwe,
	output logic                    port1_ack,
	output sdram_pkg::word_t        port1_q,
	output logic                    port2_ack,
	output sdram_pkg::dword_t       port2_q,
	output sdram_pkg::word_t        cpu1_q,
	output sdram_pkg::word_t        cpu2_q,
	output sdram_pkg::dword_t       sp_q
);

	sdram_pkg::sdram_cmd_t cmd;           // registered command on the pins
	logic                  dq_oe;
	sdram_pkg::word_t      dq_out;
	sdram_pkg::word_t      sd_din;        // dq registered every cycle
	sdram_pkg::port_sel_t  port_l [2];    // owner of each slot this frame
	sdram_pkg::waddr_t     addr_l [2];
	sdram_pkg::word_t      din_l [2];
	logic [1:0]            ds_l [2];
	logic [1:0]            oe_l;          // read in flight, per slot
	logic [1:0]            we_l;          // write in flight, per slot
	logic [9:0]            refresh_cnt;
	logic                  need_refresh;
	logic                  do_refresh;
	logic                  go_cas0, go_cas1;
	logic                  cap_rd0, cap_rd1, cap_rd1b;

	assign {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe} = cmd;
	assign sdram_dq = dq_oe ? dq_out : 16'hzzzz;

	// --------------------------------------------------------------------------
	// phase decode
	// --------------------------------------------------------------------------

	assign take0 = (frame_phase == sdram_pkg::PH_RAS0) && !init_busy;
	assign take1 = (frame_phase == sdram_pkg::PH_RAS1) && !init_busy;

	assign go_cas0  = (frame_phase == sdram_pkg::PH_CAS0) && (oe_l[0] || we_l[0]);
	assign go_cas1  = (frame_phase == sdram_pkg::PH_CAS1) && (oe_l[1] || we_l[1]);
	assign cap_rd0  = (frame_phase == sdram_pkg::PH_READ0) && oe_l[0];
	assign cap_rd1  = (frame_phase == sdram_pkg::PH_READ1) && oe_l[1];
	assign cap_rd1b = (frame_phase == sdram_pkg::PH_READ1B) && oe_l[1];

	assign need_refresh = (refresh_cnt >= sdram_pkg::RFRSH_CYCLES);
	// slot 1 idle and nothing open on slot 0 banks
	assign do_refresh = take1 && (sel1 == sdram_pkg::PORT_NONE) && need_refresh
		&& !oe_l[0] && !we_l[0];

	// --------------------------------------------------------------------------
	// frame, commands, masks and acknowledges
	// --------------------------------------------------------------------------

	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			frame_phase              <= sdram_pkg::PH_RAS0;
			cmd                      <= sdram_pkg::CMD_NOP;
			{sdram_dqmh, sdram_dqml} <= 2'b11;
			dq_oe                    <= 1'b0;
			port1_ack                <= 1'b0;
			port2_ack                <= 1'b0;
			port_l[0]                <= sdram_pkg::PORT_NONE;
			port_l[1]                <= sdram_pkg::PORT_NONE;
			oe_l                     <= 2'b00;
			we_l                     <= 2'b00;
			refresh_busy             <= 1'b0;
			refresh_cnt              <= 10'd0;
		end else begin
			if (frame_phase == sdram_pkg::PH_LAST)
				frame_phase <= sdram_pkg::PH_RAS0;
			else
				frame_phase <= sdram_pkg::frame_phase_t'(frame_phase + 3'd1);
			cmd                      <= sdram_pkg::CMD_NOP;  // idle by default
			{sdram_dqmh, sdram_dqml} <= 2'b11;
			dq_oe                    <= 1'b0;
			if (!need_refresh)
				refresh_cnt <= refresh_cnt + 10'd1;  // saturates at the interval

			if (init_busy) begin
				cmd <= init_cmd;
			end else begin
				// ras, bank 0/1
				if (take0) begin
					port_l[0] <= sel0;
					oe_l[0]   <= (sel0 != sdram_pkg::PORT_NONE) && !sel0_we;
					we_l[0]   <= (sel0 != sdram_pkg::PORT_NONE) && sel0_we;
					if (sel0 != sdram_pkg::PORT_NONE)
						cmd <= sdram_pkg::CMD_ACTIVE;
				end
				// ras, bank 2/3, or refresh in its place
				if (take1) begin
					port_l[1]    <= sel1;
					oe_l[1]      <= (sel1 != sdram_pkg::PORT_NONE) && !sel1_we;
					we_l[1]      <= (sel1 != sdram_pkg::PORT_NONE) && sel1_we;
					refresh_busy <= do_refresh;  // holds slot 0 off for a frame
					if (sel1 != sdram_pkg::PORT_NONE)
						cmd <= sdram_pkg::CMD_ACTIVE;
					if (do_refresh) begin
						cmd         <= sdram_pkg::CMD_AUTO_REFRESH;
						refresh_cnt <= 10'd0;
					end
				end

				if (go_cas0) begin
					cmd                      <= we_l[0] ? sdram_pkg::CMD_WRITE : sdram_pkg::CMD_READ;
					{sdram_dqmh, sdram_dqml} <= ~ds_l[0];
					dq_oe                    <= we_l[0];
					if (we_l[0])
						port1_ack <= port1_req;  // write done at cas
				end
				if (go_cas1) begin
					cmd                      <= we_l[1] ? sdram_pkg::CMD_WRITE : sdram_pkg::CMD_READ;
					{sdram_dqmh, sdram_dqml} <= ~ds_l[1];
					dq_oe                    <= we_l[1];
					if (we_l[1])
						port2_ack <= port2_req;
				end

				// dqm for the second burst word of slot 1, two cycles ahead
				if (frame_phase == sdram_pkg::PH_RAS0 && oe_l[1])
					{sdram_dqmh, sdram_dqml} <= ~ds_l[1];

				if (cap_rd0 && port_l[0] == sdram_pkg::PORT_REQ)
					port1_ack <= port1_req;
				if (cap_rd1b && port_l[1] == sdram_pkg::PORT_REQ)
					port2_ack <= port2_req;  // with the high word
			end
		end
	end

	// --------------------------------------------------------------------------
	// address bus, write data and read capture
	// --------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		sd_din <= sdram_dq;
		if (init_busy) begin
			if (init_cmd == sdram_pkg::CMD_LOAD_MODE)
				sdram_a <= sdram_pkg::MODE_WORD;
			else
				sdram_a <= {2'b00, init_a10, 10'd0};
			sdram_ba <= 2'b00;
		end else begin
			if (take0) begin
				addr_l[0] <= sel0_addr;
				din_l[0]  <= sel0_d;
				ds_l[0]   <= sel0_ds;
				sdram_a   <= sel0_addr[21:9];   // row
				sdram_ba  <= sel0_addr[23:22];
			end
			if (take1) begin
				addr_l[1] <= sel1_addr;
				din_l[1]  <= sel1_d;
				ds_l[1]   <= sel1_ds;
				sdram_a   <= sel1_addr[21:9];
				sdram_ba  <= sel1_addr[23:22];
			end
			if (go_cas0) begin
				sdram_a  <= {4'b0010, addr_l[0][8:0]};  // column, a10 auto precharge
				sdram_ba <= addr_l[0][23:22];
				dq_out   <= din_l[0];
			end
			if (go_cas1) begin
				sdram_a  <= {4'b0010, addr_l[1][8:0]};
				sdram_ba <= addr_l[1][23:22];
				dq_out   <= din_l[1];
			end

			if (cap_rd0) begin
				case (port_l[0])
					sdram_pkg::PORT_REQ:  port1_q <= sd_din;
					sdram_pkg::PORT_CPU1: cpu1_q  <= sd_din;
					sdram_pkg::PORT_CPU2: cpu2_q  <= sd_din;
					default: ;
				endcase
			end
			if (cap_rd1) begin
				case (port_l[1])
					sdram_pkg::PORT_REQ: port2_q[15:0] <= sd_din;  // low word first
					sdram_pkg::PORT_SP:  sp_q[15:0]    <= sd_din;
					default: ;
				endcase
			end
			if (cap_rd1b) begin
				case (port_l[1])
					sdram_pkg::PORT_REQ: port2_q[31:16] <= sd_din;
					sdram_pkg::PORT_SP:  sp_q[31:16]    <= sd_din;
					default: ;
				endcase
			end
		end
	end

endmodule

//--- hdl/sdram_subsys.sv
`timescale 1ns/1ps

module sdram_subsys (
	input  logic              clk,
	input  logic              init_n,
	// chip pins
	inout  wire  [15:0]       sdram_dq,
	output logic [12:0]       sdram_a,
	output logic [1:0]        sdram_ba,
	output logic              sdram_dqml,
	output logic              sdram_dqmh,
	output logic              sdram_ncs,
	output logic              sdram_nras,
	output logic              sdram_ncas,
	output logic              sdram_nwe,
	// slot 0 clients
	input  logic              port1_req,
	output logic              port1_ack,
	input  logic              port1_we,
	input  sdram_pkg::waddr_t port1_a,
	input  logic [1:0]        port1_ds,
	input  sdram_pkg::word_t  port1_d,
	output sdram_pkg::word_t  port1_q,
	input  logic [15:0]       cpu1_addr,  // word address
	output sdram_pkg::word_t  cpu1_q,
	input  logic [15:0]       cpu2_addr,
	output sdram_pkg::word_t  cpu2_q,
	// slot 1 clients
	input  logic              port2_req,
	output logic              port2_ack,
	input  logic              port2_we,
	input  sdram_pkg::waddr_t port2_a,
	input  logic [1:0]        port2_ds,
	input  sdram_pkg::word_t  port2_d,
	output sdram_pkg::dword_t port2_q,
	input  logic [15:0]       sp_addr,    // dword address
	output sdram_pkg::dword_t sp_q
);

	sdram_pkg::frame_phase_t frame_phase;
	sdram_pkg::sdram_cmd_t   init_cmd;
	logic                    init_busy, init_a10, refresh_busy;
	logic                    take0, take1;
	logic                    req_state0, req_state1;
	sdram_pkg::port_sel_t    sel0, sel1;
	sdram_pkg::waddr_t       sel0_addr, sel1_addr;
	logic                    sel0_we, sel1_we;
	logic [1:0]              sel0_ds, sel1_ds;
	sdram_pkg::word_t        sel0_d, sel1_d;

	sdram_init_seq init_seq_inst (
		.clk         (clk),
		.init_n      (init_n),
		.frame_phase (frame_phase),
		.init_busy   (init_busy),
		.init_cmd    (init_cmd),
		.init_a10    (init_a10)
	);

	// --------------------------------------------------------------------------
	// slot arbiters
	// --------------------------------------------------------------------------

	sdram_port_arbiter #(.SLOT(0)) arb0_inst (
		.clk       (clk),
		.init_n    (init_n),
		.take      (take0),
		.slot_hold (refresh_busy),
		.req       (port1_req),
		.we        (port1_we),
		.ds        (port1_ds),
		.d         (port1_d),
		.a         (port1_a),
		.rd0_addr  (cpu1_addr),
		.rd1_addr  (cpu2_addr),
		.sel       (sel0),
		.sel_addr  (sel0_addr),
		.sel_we    (sel0_we),
		.sel_ds    (sel0_ds),
		.sel_d     (sel0_d),
		.req_state (req_state0)
	);

	sdram_port_arbiter #(.SLOT(1)) arb1_inst (
		.clk       (clk),
		.init_n    (init_n),
		.take      (take1),
		.slot_hold (1'b0),       // refresh only runs in an idle slot 1
		.req       (port2_req),
		.we        (port2_we),
		.ds        (port2_ds),
		.d         (port2_d),
		.a         (port2_a),
		.rd0_addr  (sp_addr),
		.rd1_addr  (16'd0),      // no second read port, never differs from reset
		.sel       (sel1),
		.sel_addr  (sel1_addr),
		.sel_we    (sel1_we),
		.sel_ds    (sel1_ds),
		.sel_d     (sel1_d),
		.req_state (req_state1)
	);

	sdram_ctrl ctrl_inst (
		.clk          (clk),
		.init_n       (init_n),
		.init_busy    (init_busy),
		.init_cmd     (init_cmd),
		.init_a10     (init_a10),
		.sel0         (sel0),
		.sel0_addr    (sel0_addr),
		.sel0_we      (sel0_we),
		.sel0_ds      (sel0_ds),
		.sel0_d       (sel0_d),
		.sel1         (sel1),
		.sel1_addr    (sel1_addr),
		.sel1_we      (sel1_we),
		.sel1_ds      (sel1_ds),
		.sel1_d       (sel1_d),
		.port1_req    (req_state0),  // ack copies the accepted toggle
		.port2_req    (req_state1),
		.frame_phase  (frame_phase),
		.take0        (take0),
		.take1        (take1),
		.refresh_busy (refresh_busy),
		.sdram_dq     (sdram_dq),
		.sdram_a      (sdram_a),
		.sdram_ba     (sdram_ba),
		.sdram_dqml   (sdram_dqml),
		.sdram_dqmh   (sdram_dqmh),
		.sdram_ncs    (sdram_ncs),
		.sdram_nras   (sdram_nras),
		.sdram_ncas   (sdram_ncas),
		.sdram_nwe    (sdram_nwe),
		.port1_ack    (port1_ack),
		.port1_q      (port1_q),
		.port2_ack    (port2_ack),
		.port2_q      (port2_q),
		.cpu1_q       (cpu1_q),
		.cpu2_q       (cpu2_q),
		.sp_q         (sp_q)
	);

endmodule

//--- bench/sdram_chip_model.sv
`timescale 1ns/1ps

module sdram_chip_model (
	input  logic        clk,
	inout  wire  [15:0] dq,
	input  logic [12:0] a,
	input  logic [1:0]  ba,
	input  logic        dqml,
	input  logic        dqmh,
	input  logic        ncs,
	input  logic        nras,
	input  logic        ncas,
	input  logic        nwe,
	output int          refresh_count  // auto refresh commands seen
);

	sdram_pkg::word_t      mem [int unsigned];  // sparse, keyed by {bank, row, col}
	logic [12:0]           open_row [4];
	sdram_pkg::sdram_cmd_t cmd;
	logic [1:0]            dqm;
	logic [1:0]            dqm_q;       // dqm one edge back, read mask latency 2
	logic                  stage_vld;   // a word goes out at the next edge
	sdram_pkg::waddr_t     stage_addr;
	logic                  burst_next;  // second word of the burst still due
	sdram_pkg::waddr_t     next_addr;
	logic [1:0]            drv_en;      // per byte
	sdram_pkg::word_t      drv_data;

	assign cmd = sdram_pkg::sdram_cmd_t'({ncs, nras, ncas, nwe});
	assign dqm = {dqmh, dqml};
	assign dq[7:0]  = drv_en[0] ? drv_data[7:0] : 8'hzz;
	assign dq[15:8] = drv_en[1] ? drv_data[15:8] : 8'hzz;

	// unwritten words, every address bit shows up in the pattern
	function automatic sdram_pkg::word_t fill_word(input sdram_pkg::waddr_t wa);
		return {wa[7:0], wa[23:16]} ^ wa[15:0] ^ 16'h6c1d;
	endfunction

	function automatic sdram_pkg::word_t read_word(input sdram_pkg::waddr_t wa);
		if (mem.exists(wa))
			return mem[wa];
		return fill_word(wa);
	endfunction

	initial begin
		refresh_count = 0;
		dqm_q         = 2'b11;
		stage_vld     = 1'b0;
		burst_next    = 1'b0;
		drv_en        = 2'b00;
	end

	// --------------------------------------------------------------------------
	// command decode, CL2 read pipe, masked writes
	// --------------------------------------------------------------------------

	always @(posedge clk) begin
		sdram_pkg::waddr_t wa;
		sdram_pkg::word_t  wd;
		wa = {ba, open_row[ba], a[8:0]};  // column from a[8:0], a10 is auto precharge
		dqm_q      <= dqm;
		drv_en     <= stage_vld ? ~dqm_q : 2'b00;
		drv_data   <= read_word(stage_addr);
		stage_vld  <= burst_next;
		stage_addr <= next_addr;
		burst_next <= 1'b0;
		case (cmd)
			sdram_pkg::CMD_ACTIVE: open_row[ba] <= a;
			sdram_pkg::CMD_READ: begin
				stage_vld  <= 1'b1;
				stage_addr <= wa;
				burst_next <= 1'b1;
				next_addr  <= {wa[23:1], ~wa[0]};  // sequential, wraps inside the pair
			end
			sdram_pkg::CMD_WRITE: begin
				wd = read_word(wa);
				if (!dqm[0])
					wd[7:0] = dq[7:0];
				if (!dqm[1])
					wd[15:8] = dq[15:8];
				mem[wa] = wd;
				stage_vld  <= 1'b0;   // write cuts off a running read burst
				burst_next <= 1'b0;
			end
			sdram_pkg::CMD_AUTO_REFRESH: refresh_count <= refresh_count + 1;
			default: ;
		endcase
	end

endmodule

//--- bench/tb_sdram_subsys.sv
`timescale 1ns/1ps

module tb_sdram_subsys;

	localparam int FRAME       = 7;
	localparam int N_ACC       = 8;     // writes per general port
	localparam int N_RD        = 6;     // address changes per read-only port
	localparam int SETTLE_FR   = 5;     // two reads back to back plus a frame lost to refresh
	localparam int IDLE_CYCLES = 1800;
	// 5 * N_ACC port accesses of at most 4 frames each
	localparam int TIMEOUT_CYCLES = FRAME * (int'(sdram_pkg::RESET_FRAMES) + 16
		+ 4 * 5 * N_ACC + 2 * SETTLE_FR * N_RD) + IDLE_CYCLES;

	logic              clk;
	logic              init_n;
	wire  [15:0]       sdram_dq;
	logic [12:0]       sdram_a;
	logic [1:0]        sdram_ba;
	logic              sdram_dqml, sdram_dqmh;
	logic              sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe;
	logic              port1_req, port1_ack, port1_we;
	sdram_pkg::waddr_t port1_a;
	logic [1:0]        port1_ds;
	sdram_pkg::word_t  port1_d, port1_q;
	logic [15:0]       cpu1_addr, cpu2_addr;
	sdram_pkg::word_t  cpu1_q, cpu2_q;
	logic              port2_req, port2_ack, port2_we;
	sdram_pkg::waddr_t port2_a;
	logic [1:0]        port2_ds;
	sdram_pkg::word_t  port2_d;
	sdram_pkg::dword_t port2_q;
	logic [15:0]       sp_addr;
	sdram_pkg::dword_t sp_q;
	int                refresh_count;

	logic [31:0]           lfsr = 32'h3922_52bd;
	int                    cycle_cnt = 0;
	sdram_pkg::word_t      ref_mem [int unsigned];  // expected chip contents
	sdram_pkg::sdram_cmd_t pin_cmd;
	sdram_pkg::sdram_cmd_t boot_cmd [$];            // non-nop commands from reset on
	logic [12:0]           boot_a [$];

	assign pin_cmd = sdram_pkg::sdram_cmd_t'({sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe});

	sdram_subsys sdram_subsys_inst (
		.clk (clk), .init_n (init_n),
		.sdram_dq (sdram_dq), .sdram_a (sdram_a), .sdram_ba (sdram_ba),
		.sdram_dqml (sdram_dqml), .sdram_dqmh (sdram_dqmh), .sdram_ncs (sdram_ncs),
		.sdram_nras (sdram_nras), .sdram_ncas (sdram_ncas), .sdram_nwe (sdram_nwe),
		.port1_req (port1_req), .port1_ack (port1_ack), .port1_we (port1_we),
		.port1_a (port1_a), .port1_ds (port1_ds), .port1_d (port1_d), .port1_q (port1_q),
		.cpu1_addr (cpu1_addr), .cpu1_q (cpu1_q), .cpu2_addr (cpu2_addr), .cpu2_q (cpu2_q),
		.port2_req (port2_req), .port2_ack (port2_ack), .port2_we (port2_we),
		.port2_a (port2_a), .port2_ds (port2_ds), .port2_d (port2_d), .port2_q (port2_q),
		.sp_addr (sp_addr), .sp_q (sp_q)
	);

	sdram_chip_model chip_inst (
		.clk (clk), .dq (sdram_dq), .a (sdram_a), .ba (sdram_ba),
		.dqml (sdram_dqml), .dqmh (sdram_dqmh), .ncs (sdram_ncs), .nras (sdram_nras),
		.ncas (sdram_ncas), .nwe (sdram_nwe), .refresh_count (refresh_count)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// --------------------------------------------------------------------------
	// random source, reference memory, checks
	// --------------------------------------------------------------------------

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = 32'd0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);   // one step per bit
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic sdram_pkg::word_t fill_word(input sdram_pkg::waddr_t wa);
		return {wa[7:0], wa[23:16]} ^ wa[15:0] ^ 16'h6c1d;  // power-up contents of the model
	endfunction

	function automatic sdram_pkg::word_t ref_read(input sdram_pkg::waddr_t wa);
		if (ref_mem.exists(wa))
			return ref_mem[wa];
		return fill_word(wa);
	endfunction

	function automatic void ref_write(input sdram_pkg::waddr_t wa, input logic [1:0] ds,
		input sdram_pkg::word_t d);
		sdram_pkg::word_t w;
		w = ref_read(wa);
		if (ds[0])
			w[7:0] = d[7:0];
		if (ds[1])
			w[15:8] = d[15:8];
		ref_mem[wa] = w;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input sdram_pkg::word_t exp,
		input sdram_pkg::word_t act);
		if (act !== exp)
			abort_run($sformatf("FAILED t=%0t %s expected %h actual %h", $time, name, exp, act));
	endtask

	task automatic check_dword(input string name, input sdram_pkg::dword_t exp,
		input sdram_pkg::dword_t act);
		if (act !== exp)
			abort_run($sformatf("FAILED t=%0t %s expected %h actual %h", $time, name, exp, act));
	endtask

	task automatic check_cmd(input string name, input sdram_pkg::sdram_cmd_t exp,
		input sdram_pkg::sdram_cmd_t act);
		if (act !== exp)
			abort_run($sformatf("FAILED t=%0t %s expected %s actual %s (%b)", $time, name,
				exp.name(), act.name(), act));
	endtask

	// toggle handshake that starts and ends on a falling edge
	task automatic port1_access(input logic we, input sdram_pkg::waddr_t wa,
		input logic [1:0] ds, input sdram_pkg::word_t d);
		port1_we  = we;
		port1_a   = wa;
		port1_ds  = ds;
		port1_d   = d;
		port1_req = ~port1_req;
		@(negedge clk);
		while (port1_ack !== port1_req)
			@(negedge clk);
	endtask

	task automatic port2_access(input logic we, input sdram_pkg::waddr_t wa,
		input logic [1:0] ds, input sdram_pkg::word_t d);
		port2_we  = we;
		port2_a   = wa;
		port2_ds  = ds;
		port2_d   = d;
		port2_req = ~port2_req;
		@(negedge clk);
		while (port2_ack !== port2_req)
			@(negedge clk);
	endtask

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			abort_run($sformatf("timeout, run still going after %0d cycles", cycle_cnt));
	end

	// pins are stable on the falling edge
	always @(negedge clk) begin
		if (init_n && boot_cmd.size() < 8 && pin_cmd != sdram_pkg::CMD_NOP) begin
			boot_cmd.push_back(pin_cmd);
			boot_a.push_back(sdram_a);
		end
	end

	// --------------------------------------------------------------------------
	// test sequence
	// --------------------------------------------------------------------------

	initial begin
		sdram_pkg::waddr_t p1_addr [$];
		sdram_pkg::waddr_t p2_addr [$];
		sdram_pkg::waddr_t wa;
		logic [31:0]       rv;
		logic [15:0]       ra, rb;
		int                r0;

		init_n    = 1'b0;
		port1_req = 1'b0;
		port1_we  = 1'b0;
		port1_a   = '0;
		port1_ds  = 2'b11;
		port1_d   = '0;
		cpu1_addr = 16'd0;  // same as the arbiter's reset state so nothing is fetched
		cpu2_addr = 16'd0;
		port2_req = 1'b0;
		port2_we  = 1'b0;
		port2_a   = 24'h800000;
		port2_ds  = 2'b11;
		port2_d   = '0;
		sp_addr   = 16'd0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		init_n = 1'b1;
		// each general port asks for a read during power-up and is served only afterwards
		port1_req = 1'b1;
		port2_req = 1'b1;

		// no ack may move during power-up
		while (sdram_subsys_inst.init_busy) begin
			if (port1_ack !== 1'b0 || port2_ack !== 1'b0)
				abort_run("an ack changed while the power-up sequence was running");
			@(negedge clk);
		end
		if (boot_cmd.size() != 4)
			abort_run($sformatf("power-up gave %0d commands instead of 4", boot_cmd.size()));
		check_cmd("power-up cmd 0", sdram_pkg::CMD_PRECHARGE, boot_cmd[0]);
		check_word("sdram_a[10] on precharge", 16'd1, sdram_pkg::word_t'(boot_a[0][10]));
		check_cmd("power-up cmd 1", sdram_pkg::CMD_AUTO_REFRESH, boot_cmd[1]);
		check_cmd("power-up cmd 2", sdram_pkg::CMD_AUTO_REFRESH, boot_cmd[2]);
		check_cmd("power-up cmd 3", sdram_pkg::CMD_LOAD_MODE, boot_cmd[3]);
		// single writes, standard mode, CL2, sequential bursts of two
		check_word("sdram_a on load mode", {3'b000, 3'b000, 1'b1, 2'b00, 3'd2, 1'b0, 3'b001},
			sdram_pkg::word_t'(boot_a[3]));

		// the requests held back by power-up complete now
		while (port1_ack !== port1_req || port2_ack !== port2_req)
			@(negedge clk);
		check_word("port1_q", ref_read(port1_a), port1_q);
		check_dword("port2_q", {ref_read({port2_a[23:1], 1'b1}), ref_read(port2_a)},
			port2_q);

		// masked port1 writes into banks 0/1 then reads back
		for (int i = 0; i < N_ACC; i++) begin
			rv = rand_bits(17);
			wa = {1'b0, rv[16], 6'd0, rv[15:0]};
			rv = rand_bits(18);
			port1_access(1'b1, wa, rv[17:16], rv[15:0]);
			ref_write(wa, rv[17:16], rv[15:0]);
			p1_addr.push_back(wa);
		end
		foreach (p1_addr[i]) begin
			port1_access(1'b0, p1_addr[i], 2'b11, 16'h0000);
			check_word("port1_q", ref_read(p1_addr[i]), port1_q);
		end

		// port2 word pairs into bank 2 then 32-bit reads
		for (int i = 0; i < N_ACC; i++) begin
			rv = rand_bits(16);
			wa = {1'b1, 6'd0, rv[15:0], 1'b0};
			rv = rand_bits(18);
			port2_access(1'b1, wa, rv[17:16], rv[15:0]);
			ref_write(wa, rv[17:16], rv[15:0]);
			rv = rand_bits(18);
			port2_access(1'b1, {wa[23:1], 1'b1}, rv[17:16], rv[15:0]);
			ref_write({wa[23:1], 1'b1}, rv[17:16], rv[15:0]);
			p2_addr.push_back(wa);
		end
		foreach (p2_addr[i]) begin
			port2_access(1'b0, p2_addr[i], 2'b11, 16'h0000);
			check_dword("port2_q", {ref_read({p2_addr[i][23:1], 1'b1}), ref_read(p2_addr[i])},
				port2_q);
		end

		// cpu fetch ports with port1 idle
		for (int i = 0; i < N_RD; i++) begin
			ra = p1_addr[i][15:0];
			rv = rand_bits(16);
			rb = rv[15:0];
			if (ra == 16'd0)
				ra = 16'd1;  // zero counts as already fetched
			if (rb == 16'd0)
				rb = 16'd1;
			cpu1_addr = ra;
			cpu2_addr = rb;
			repeat (SETTLE_FR * FRAME) @(negedge clk);
			check_word("cpu1_q", ref_read({8'h00, ra}), cpu1_q);
			check_word("cpu2_q", ref_read({8'h00, rb}), cpu2_q);
		end

		// sprite port reads dword addresses in bank 2
		for (int i = 0; i < N_RD; i++) begin
			ra = p2_addr[i][16:1];
			if (ra == 16'd0)
				ra = 16'd1;
			sp_addr = ra;
			repeat (SETTLE_FR * FRAME) @(negedge clk);
			check_dword("sp_q",
				{ref_read({1'b1, 6'd0, ra, 1'b1}), ref_read({1'b1, 6'd0, ra, 1'b0})}, sp_q);
		end

		// refresh has to keep up over a long idle stretch
		r0 = refresh_count;
		repeat (IDLE_CYCLES) @(negedge clk);
		if (refresh_count - r0 < IDLE_CYCLES / (int'(sdram_pkg::RFRSH_CYCLES) + FRAME)) begin
			abort_run($sformatf("only %0d refreshes in %0d idle cycles", refresh_count - r0,
				IDLE_CYCLES));
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

//--- project.f
hdl/sdram_pkg.sv
hdl/sdram_init_seq.sv
hdl/sdram_port_arbiter.sv
hdl/sdram_ctrl.sv
hdl/sdram_subsys.sv
bench/sdram_chip_model.sv
bench/tb_sdram_subsys.sv

//--- Bender.yml
package:
  name: sdram_subsys

sources:
  - files:
      - hdl/sdram_pkg.sv
      - hdl/sdram_init_seq.sv
      - hdl/sdram_port_arbiter.sv
      - hdl/sdram_ctrl.sv
      - hdl/sdram_subsys.sv
  - target: test
    files:
      - bench/sdram_chip_model.sv
      - bench/tb_sdram_subsys.sv
